// ==== design/scalar_pkg.sv ====
/*
 * Scalar unit shared definitions
 * Widths, instruction field positions, opcodes and the run-control states,
 * plus small decode helpers used by issue and execute
 */
`default_nettype none

package scalar_pkg;

	//////////////////////////////////////////////////
	// Widths
	localparam int DATA_W     = 32;
	localparam int NUM_REGS   = 16;
	localparam int REG_W      = 4;
	localparam int IMEM_DEPTH = 64;
	localparam int PC_W       = 6;
	localparam int INSTR_W    = 32;
	localparam int OP_W       = 4;
	localparam int IMM_W      = 16;
	localparam int SHAMT_W    = 5;

	// Field positions, top down
	localparam int OP_MSB   = 31;
	localparam int DST_MSB  = 27;
	localparam int SRC1_MSB = 23;
	localparam int SRC2_MSB = 19;
	localparam int IMM_MSB  = 15;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [REG_W-1:0]   reg_idx_t;
	typedef logic [PC_W-1:0]    pc_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [IMM_W-1:0]   imm_t;

	typedef enum logic [OP_W-1:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SHL  = 4'h5,
		OP_SHR  = 4'h6,
		OP_ADDI = 4'h7,
		OP_LDI  = 4'h8,
		OP_BNZ  = 4'h9,   // Target in imm low bits
		OP_HALT = 4'hA
	} opcode_e;

	typedef enum logic [1:0] {
		RUN_IDLE,
		RUN_ACTIVE,
		RUN_STOP
	} run_state_e;

	//////////////////////////////////////////////////
	// Decode helpers
	function automatic logic writes_dst(opcode_e op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SHL, OP_SHR, OP_ADDI, OP_LDI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic reads_src1(opcode_e op);
		return writes_dst(op) && op != OP_LDI || op == OP_BNZ;
	endfunction

	function automatic logic reads_src2(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
	endfunction

	function automatic data_t sext_imm(imm_t imm);
		return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
	endfunction

endpackage

`default_nettype wire

// ==== design/pipe_if.sv ====
/*
 * Pipeline links
 * fetch_if carries a valid/ready word from fetch to issue,
 * exec_if carries one issued instruction per valid cycle to execute
 */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if
	import scalar_pkg::*;
();
	logic   valid;
	logic   ready;
	instr_t instr;
	pc_t    pc;

	modport producer (output valid, output instr, output pc, input ready);
	modport consumer (input valid, input instr, input pc, output ready);
endinterface

interface exec_if
	import scalar_pkg::*;
();
	logic     valid;   // No back-pressure
	opcode_e  op;
	reg_idx_t dst;
	data_t    a;
	data_t    b;
	imm_t     imm;

	modport source (output valid, output op, output dst, output a, output b, output imm);
	modport sink (input valid, input op, input dst, input a, input b, input imm);
endinterface

`default_nettype wire

// ==== design/instr_mem.sv ====
/*
 * Instruction memory
 * Host writes one word per load handshake, fetch reads
 * with one cycle of latency every cycle
 */
`timescale 1ns/1ps
`default_nettype none

module instr_mem
	import scalar_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   load_valid,
	input  logic   load_ready,
	input  pc_t    load_addr,
	input  instr_t load_instr,
	input  pc_t    rd_addr,
	output instr_t rd_data
);

	instr_t mem [IMEM_DEPTH];
	logic   load_fire;

	assign load_fire = load_valid && load_ready;   // Full handshake

	// Program store
	always_ff @(posedge clock) begin
		if (load_fire) begin
			mem[load_addr] <= load_instr;
		end
	end

	// Registered read port
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
/*
 * Fetch stage
 * Run control FSM, program counter and a one-word fetch buffer.
 * A word that the buffer cannot take is re-read from memory until it can.
 * A taken branch flushes the buffer and the word in flight
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      start,
	input  logic      br_done,
	input  logic      br_taken,
	input  pc_t       br_target,
	input  logic      halt_done,
	output pc_t       rd_addr,
	input  instr_t    rd_data,
	fetch_if.producer fetch,
	output logic      busy,
	output logic      done
);

	run_state_e state;
	pc_t        pc;            // Next address to request
	logic       inflight;      // Memory word lands this cycle
	pc_t        inflight_pc;
	logic       buf_valid;
	instr_t     buf_instr;
	pc_t        buf_pc;
	logic       can_take;
	logic       hold;
	logic       redirect;

	assign can_take = !buf_valid || fetch.ready;
	assign hold     = inflight && !can_take;
	assign redirect = br_done && br_taken;
	assign rd_addr  = hold ? inflight_pc : pc;   // Replay stalled word

	assign fetch.valid = buf_valid;
	assign fetch.instr = buf_instr;
	assign fetch.pc    = buf_pc;

	assign busy = (state == RUN_ACTIVE);
	assign done = (state == RUN_STOP);   // Single cycle, busy already low

	//////////////////////////////////////////////////
	// Run control
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RUN_IDLE;
		end else begin
			case (state)
				RUN_ACTIVE: state <= halt_done ? RUN_STOP : RUN_ACTIVE;
				default:    state <= start ? RUN_ACTIVE : RUN_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Program counter and buffer
	always_ff @(posedge clock) begin
		if (reset) begin
			pc        <= '0;
			inflight  <= 1'b0;
			buf_valid <= 1'b0;
		end else if (state != RUN_ACTIVE || halt_done) begin
			pc        <= '0;   // Next run starts at address 0
			inflight  <= 1'b0;
			buf_valid <= 1'b0;
		end else if (redirect) begin
			pc        <= br_target;
			inflight  <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (!hold) begin
				pc       <= pc + 1'b1;
				inflight <= 1'b1;
			end
			if (inflight && can_take) begin
				buf_valid <= 1'b1;
			end else if (fetch.ready) begin
				buf_valid <= 1'b0;   // Drained
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			inflight_pc <= pc;
		end
		if (inflight && can_take) begin
			buf_instr <= rd_data;
			buf_pc    <= inflight_pc;
		end
	end

endmodule

`default_nettype wire

// ==== design/hazard_check.sv ====
/*
 * Hazard check and issue
 * Holds one fetched instruction, checks a scoreboard of pending
 * destination writes, reads operands and registers them for execute.
 * Stalls behind an unresolved BNZ and stops accepting after HALT
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_check
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	fetch_if.consumer fetch,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	input  data_t     rd1,
	input  data_t     rd2,
	input  logic      wb_valid,
	input  reg_idx_t  wb_index,
	input  logic      br_done,
	exec_if.source    exec
);

	logic                entry_valid;
	instr_t              entry_instr;
	opcode_e             op;
	reg_idx_t            dst;
	imm_t                imm;
	logic [NUM_REGS-1:0] sb;        // Pending destination writes
	logic [NUM_REGS-1:0] wb_clear;
	logic [NUM_REGS-1:0] dst_mask;
	logic [NUM_REGS-1:0] sb_busy;
	logic                hazard;
	logic                issue;
	logic                ctrl_op;
	logic                bnz_pending;
	logic [1:0]          halt_hold;

	// Decode
	assign op  = opcode_e'(entry_instr[OP_MSB -: OP_W]);
	assign dst = entry_instr[DST_MSB -: REG_W];
	assign rs1 = entry_instr[SRC1_MSB -: REG_W];
	assign rs2 = entry_instr[SRC2_MSB -: REG_W];
	assign imm = entry_instr[IMM_MSB:0];

	always_comb begin
		wb_clear = '0;
		dst_mask = '0;
		if (wb_valid) begin
			wb_clear[wb_index] = 1'b1;
		end
		dst_mask[dst] = 1'b1;
	end

	// A write-back landing this cycle releases its bit at once
	assign sb_busy = sb & ~wb_clear;
	assign hazard  = (reads_src1(op) && sb_busy[rs1]) ||
	                 (reads_src2(op) && sb_busy[rs2]) ||
	                 (writes_dst(op) && sb_busy[dst]);
	assign issue   = entry_valid && !hazard && !bnz_pending;
	assign ctrl_op = (op == OP_BNZ) || (op == OP_HALT);

	// Nothing follows a BNZ or HALT into the entry
	assign fetch.ready = !bnz_pending && (halt_hold == 2'b00) &&
	                     (!entry_valid || (issue && !ctrl_op));

	//////////////////////////////////////////////////
	// Control state
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= 1'b0;
			sb          <= '0;
			bnz_pending <= 1'b0;
			halt_hold   <= '0;
			exec.valid  <= 1'b0;
		end else begin
			if (fetch.valid && fetch.ready) begin
				entry_valid <= 1'b1;
			end else if (issue) begin
				entry_valid <= 1'b0;
			end
			sb <= sb_busy | ((issue && writes_dst(op)) ? dst_mask : '0);
			if (issue && op == OP_BNZ) begin
				bnz_pending <= 1'b1;
			end else if (br_done) begin
				bnz_pending <= 1'b0;
			end
			// Covers the cycles until the fetch flush on halt_done
			halt_hold  <= {halt_hold[0], issue && op == OP_HALT};
			exec.valid <= issue;
		end
	end

	// Entry and issue payload
	always_ff @(posedge clock) begin
		if (fetch.valid && fetch.ready) begin
			entry_instr <= fetch.instr;
		end
		if (issue) begin
			exec.op  <= op;
			exec.dst <= dst;
			exec.a   <= rd1;
			exec.b   <= rd2;
			exec.imm <= imm;
		end
	end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/*
 * Register file
 * Sixteen registers, two combinational read ports with write bypass
 * and one write port fed by write-back
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import scalar_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output data_t    rd1,
	output data_t    rd2,
	input  logic     we,
	input  reg_idx_t wa,
	input  data_t    wd
);

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// Same-cycle write is visible to the reader
	assign rd1 = (we && wa == rs1) ? wd : regs[rs1];
	assign rd2 = (we && wa == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
/*
 * Execute stage
 * Single-cycle ALU with a registered write-back, BNZ resolution into
 * the redirect signals, HALT completion and zero/negative status flags
 */
`timescale 1ns/1ps
`default_nettype none

module exec_unit
	import scalar_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	exec_if.sink     exec,
	output logic     wb_valid,
	output reg_idx_t wb_index,
	output data_t    wb_data,
	output logic     br_done,
	output logic     br_taken,
	output pc_t      br_target,
	output logic     halt_done,
	output logic     flag_zero,
	output logic     flag_neg
);

	data_t result;
	data_t imm_ext;
	logic  wr_en;
	logic  is_bnz;

	assign imm_ext = sext_imm(exec.imm);
	assign wr_en   = exec.valid && writes_dst(exec.op);
	assign is_bnz  = exec.valid && exec.op == OP_BNZ;

	//////////////////////////////////////////////////
	// ALU
	always_comb begin
		case (exec.op)
			OP_ADD:  result = exec.a + exec.b;
			OP_SUB:  result = exec.a - exec.b;
			OP_AND:  result = exec.a & exec.b;
			OP_OR:   result = exec.a | exec.b;
			OP_XOR:  result = exec.a ^ exec.b;
			OP_SHL:  result = exec.a << exec.b[SHAMT_W-1:0];
			OP_SHR:  result = exec.a >> exec.b[SHAMT_W-1:0];   // Logical
			OP_ADDI: result = exec.a + imm_ext;
			OP_LDI:  result = imm_ext;
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Write-back, redirect and status
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid  <= 1'b0;
			br_done   <= 1'b0;
			br_taken  <= 1'b0;
			halt_done <= 1'b0;
			flag_zero <= 1'b0;
			flag_neg  <= 1'b0;
		end else begin
			wb_valid  <= wr_en;
			br_done   <= is_bnz;
			br_taken  <= is_bnz && exec.a != '0;
			halt_done <= exec.valid && exec.op == OP_HALT;
			if (wr_en) begin
				flag_zero <= (result == '0);
				flag_neg  <= result[DATA_W-1];
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		wb_index  <= exec.dst;
		wb_data   <= result;
		br_target <= exec.imm[PC_W-1:0];   // Absolute target
	end

endmodule

`default_nettype wire

// ==== design/scalar_unit.sv ====
/*
 * Scalar execution unit, top level
 * Program load port, start/busy/done run control and the
 * write-back event with status flags
 */
`timescale 1ns/1ps
`default_nettype none

module scalar_unit
	import scalar_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     load_valid,
	output logic     load_ready,
	input  pc_t      load_addr,
	input  instr_t   load_instr,
	input  logic     start,
	output logic     busy,
	output logic     done,
	output logic     wb_valid,
	output reg_idx_t wb_index,
	output data_t    wb_data,
	output logic     flag_zero,
	output logic     flag_neg
);

	pc_t      rd_addr;
	instr_t   rd_data;
	reg_idx_t rs1;
	reg_idx_t rs2;
	data_t    rd1;
	data_t    rd2;
	logic     br_done;
	logic     br_taken;
	pc_t      br_target;
	logic     halt_done;

	fetch_if fetch_link ();
	exec_if  exec_link ();

	assign load_ready = ~busy;   // Host held off during a run

	instr_mem u_imem (
		.clock(clock), .reset(reset),
		.load_valid(load_valid), .load_ready(load_ready),
		.load_addr(load_addr), .load_instr(load_instr),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	fetch_stage u_fetch (
		.clock(clock), .reset(reset), .start(start),
		.br_done(br_done), .br_taken(br_taken), .br_target(br_target),
		.halt_done(halt_done), .rd_addr(rd_addr), .rd_data(rd_data),
		.fetch(fetch_link), .busy(busy), .done(done)
	);

	hazard_check u_hazard (
		.clock(clock), .reset(reset), .fetch(fetch_link),
		.rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
		.wb_valid(wb_valid), .wb_index(wb_index),
		.br_done(br_done), .exec(exec_link)
	);

	reg_file u_regs (
		.clock(clock), .reset(reset),
		.rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
		.we(wb_valid), .wa(wb_index), .wd(wb_data)
	);

	exec_unit u_exec (
		.clock(clock), .reset(reset), .exec(exec_link),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data),
		.br_done(br_done), .br_taken(br_taken), .br_target(br_target),
		.halt_done(halt_done), .flag_zero(flag_zero), .flag_neg(flag_neg)
	);

endmodule

`default_nettype wire

// ==== sim/scalar_checker.sv ====
/*
 * Scalar unit checker
 * Rebuilds the program from the load port, runs an instruction-set
 * model on each start and compares every write-back and the flags
 */
`timescale 1ns/1ps
`default_nettype none

module scalar_checker
	import scalar_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     load_valid,
	input  logic     load_ready,
	input  pc_t      load_addr,
	input  instr_t   load_instr,
	input  logic     start,
	input  logic     busy,
	input  logic     done,
	input  logic     wb_valid,
	input  reg_idx_t wb_index,
	input  data_t    wb_data,
	input  logic     flag_zero,
	input  logic     flag_neg,
	output int       error_count
);

	localparam int STEP_LIMIT = 1000;   // Guards a runaway loop

	instr_t   image [IMEM_DEPTH];
	data_t    model_regs [NUM_REGS];
	reg_idx_t exp_index [$];
	data_t    exp_data [$];

	//////////////////////////////////////////////////
	// Instruction-set model
	task automatic run_model();
		int      pc;
		int      steps;
		logic    running;
		logic    wr;
		instr_t  w;
		opcode_e op;
		data_t   a;
		data_t   b;
		data_t   ext;
		data_t   res;
		pc      = 0;
		steps   = 0;
		running = 1'b1;
		while (running && steps < STEP_LIMIT) begin
			w   = image[pc];
			op  = opcode_e'(w[OP_MSB -: OP_W]);
			a   = model_regs[w[SRC1_MSB -: REG_W]];
			b   = model_regs[w[SRC2_MSB -: REG_W]];
			ext = {{(DATA_W-IMM_W){w[IMM_MSB]}}, w[IMM_MSB:0]};
			pc  = (pc + 1) % IMEM_DEPTH;
			steps++;
			wr  = 1'b1;
			res = '0;
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SHL:  res = a << b[4:0];
				OP_SHR:  res = a >> b[4:0];
				OP_ADDI: res = a + ext;
				OP_LDI:  res = ext;
				OP_BNZ: begin
					wr = 1'b0;
					if (a != '0) begin
						pc = int'(w[PC_W-1:0]);   // Absolute target
					end
				end
				OP_HALT: begin
					wr      = 1'b0;
					running = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				model_regs[w[DST_MSB -: REG_W]] = res;
				exp_index.push_back(w[DST_MSB -: REG_W]);
				exp_data.push_back(res);
			end
		end
	endtask

	task automatic check_value(string name, data_t got, data_t want);
		if (got !== want) begin
			error_count++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic compare_wb();
		reg_idx_t idx;
		data_t    want;
		if (exp_index.size() == 0) begin
			error_count++;
			$display("write-back to r%0d arrived with no instruction left in the model",
				wb_index);
		end else begin
			idx  = exp_index.pop_front();
			want = exp_data.pop_front();
			check_value("wb_index", data_t'(wb_index), data_t'(idx));
			check_value("wb_data", wb_data, want);
			check_value("flag_zero", data_t'(flag_zero), data_t'(want == '0));
			check_value("flag_neg", data_t'(flag_neg), data_t'(want[DATA_W-1]));
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			error_count = 0;
			model_regs  = '{default: '0};
			exp_index.delete();
			exp_data.delete();
		end else begin
			if (load_valid && load_ready) begin
				image[load_addr] = load_instr;
			end
			if (start && !busy) begin
				run_model();
			end
			if (wb_valid) begin
				compare_wb();
			end
			if (done && exp_index.size() != 0) begin
				error_count++;
				$display("run ended with %0d expected write-backs missing", exp_index.size());
				exp_index.delete();
				exp_data.delete();
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/scalar_unit_asserts.sv ====
/*
 * Protocol assertions for the scalar unit
 * Load hold-off, done pulse width, write-back only during a run
 * and a stable fetch word under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module scalar_unit_asserts
	import scalar_pkg::*;
(
	input logic   clock,
	input logic   reset,
	input logic   start,
	input logic   busy,
	input logic   done,
	input logic   load_ready,
	input logic   wb_valid,
	input logic   br_done,
	input logic   br_taken,
	input logic   halt_done,
	input logic   fetch_valid,
	input logic   fetch_ready,
	input instr_t fetch_instr,
	input pc_t    fetch_pc
);

	logic flush;

	assign flush = (br_done && br_taken) || halt_done;   // Buffer cleared

	// An accepted start closes the load port on the next edge
	load_hold: assert property (@(posedge clock) disable iff (reset)
		start && load_ready |=> !load_ready)
		else $error("load port still open after a run was started");

	done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done held for more than one cycle");

	wb_in_run: assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> busy)
		else $error("write-back while the unit is idle");

	fetch_stable: assert property (@(posedge clock) disable iff (reset)
		fetch_valid && !fetch_ready && !flush |=>
		fetch_valid && $stable(fetch_instr) && $stable(fetch_pc))
		else $error("fetch word changed while waiting for ready");

endmodule

bind scalar_unit scalar_unit_asserts u_asserts (
	.clock(clock), .reset(reset), .start(start), .busy(busy), .done(done),
	.load_ready(load_ready), .wb_valid(wb_valid),
	.br_done(br_done), .br_taken(br_taken), .halt_done(halt_done),
	.fetch_valid(fetch_link.valid), .fetch_ready(fetch_link.ready),
	.fetch_instr(fetch_link.instr), .fetch_pc(fetch_link.pc)
);

`default_nettype wire

// ==== sim/tb_scalar_unit.sv ====
/*
 * Testbench for the scalar unit
 * Loads a table of programs, runs each one, checks run control,
 * write-back counts and the load hold-off while a run is active
 */
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_unit
	import scalar_pkg::*;
();

	localparam int NUM_PROGS = 3;

	logic     clock;
	logic     reset;
	logic     load_valid;
	logic     load_ready;
	pc_t      load_addr;
	instr_t   load_instr;
	logic     start;
	logic     busy;
	logic     done;
	logic     wb_valid;
	reg_idx_t wb_index;
	data_t    wb_data;
	logic     flag_zero;
	logic     flag_neg;

	int          chk_errors;
	int          tb_errors   = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int          wb_count    = 0;
	logic [31:0] rng_state   = 32'h25d4_1ff5;

	// Program table with the write-back count each program must produce
	instr_t prog_words [$];
	int     prog_first [NUM_PROGS];
	int     prog_len [NUM_PROGS];
	int     prog_wb [NUM_PROGS];

	scalar_unit dut (
		.clock(clock), .reset(reset),
		.load_valid(load_valid), .load_ready(load_ready),
		.load_addr(load_addr), .load_instr(load_instr),
		.start(start), .busy(busy), .done(done),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data),
		.flag_zero(flag_zero), .flag_neg(flag_neg)
	);

	scalar_checker chk (
		.clock(clock), .reset(reset),
		.load_valid(load_valid), .load_ready(load_ready),
		.load_addr(load_addr), .load_instr(load_instr),
		.start(start), .busy(busy), .done(done),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data),
		.flag_zero(flag_zero), .flag_neg(flag_neg),
		.error_count(chk_errors)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		if (!reset && wb_valid) begin
			wb_count++;
		end
	end

	// Watchdog
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles with programs still running", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function imm_t next_imm();
		rng_state = xorshift32(rng_state);
		return rng_state[IMM_W-1:0];
	endfunction

	function automatic instr_t encode_instr(opcode_e op, int d, int s1, int s2, imm_t imm);
		return {op, reg_idx_t'(d), reg_idx_t'(s1), reg_idx_t'(s2), imm};
	endfunction

	task automatic close_program(int p, int exp_wb);
		prog_len[p] = prog_words.size() - prog_first[p];
		prog_wb[p]  = exp_wb;
	endtask

	task automatic build_programs();
		// ALU ops and dependent chains
		prog_first[0] = prog_words.size();
		prog_words.push_back(encode_instr(OP_LDI, 1, 0, 0, next_imm()));
		prog_words.push_back(encode_instr(OP_LDI, 2, 0, 0, next_imm()));
		prog_words.push_back(encode_instr(OP_ADD, 3, 1, 2, '0));
		prog_words.push_back(encode_instr(OP_SUB, 4, 1, 2, '0));
		prog_words.push_back(encode_instr(OP_AND, 5, 3, 4, '0));
		prog_words.push_back(encode_instr(OP_OR, 6, 5, 2, '0));
		prog_words.push_back(encode_instr(OP_XOR, 7, 6, 1, '0));
		prog_words.push_back(encode_instr(OP_LDI, 8, 0, 0, next_imm()));
		prog_words.push_back(encode_instr(OP_SHL, 9, 7, 8, '0));
		prog_words.push_back(encode_instr(OP_SHR, 10, 9, 8, '0));
		prog_words.push_back(encode_instr(OP_ADDI, 10, 10, 0, 16'hffff));
		prog_words.push_back(encode_instr(OP_ADDI, 11, 10, 0, 16'h8000));
		prog_words.push_back(encode_instr(OP_SUB, 12, 11, 11, '0));   // Zero flag
		prog_words.push_back(encode_instr(OP_HALT, 0, 0, 0, '0));
		close_program(0, 13);

		// Counted loop, r5 carried over from the first run
		prog_first[1] = prog_words.size();
		prog_words.push_back(encode_instr(OP_LDI, 1, 0, 0, 16'd4));
		prog_words.push_back(encode_instr(OP_LDI, 2, 0, 0, 16'd0));
		prog_words.push_back(encode_instr(OP_ADDI, 2, 2, 0, 16'd3));
		prog_words.push_back(encode_instr(OP_ADDI, 1, 1, 0, 16'hffff));
		prog_words.push_back(encode_instr(OP_BNZ, 0, 1, 0, 16'd2));
		prog_words.push_back(encode_instr(OP_ADD, 3, 2, 5, '0));
		prog_words.push_back(encode_instr(OP_HALT, 0, 0, 0, '0));
		prog_words.push_back(encode_instr(OP_LDI, 14, 0, 0, 16'h7777));   // Never reached
		close_program(1, 11);

		// Not-taken branch and chains on carried registers
		prog_first[2] = prog_words.size();
		prog_words.push_back(encode_instr(OP_LDI, 4, 0, 0, next_imm()));
		prog_words.push_back(encode_instr(OP_ADD, 4, 4, 4, '0));
		prog_words.push_back(encode_instr(OP_ADD, 4, 4, 4, '0));
		prog_words.push_back(encode_instr(OP_XOR, 6, 4, 3, '0));
		prog_words.push_back(encode_instr(OP_SHR, 7, 6, 1, '0));
		prog_words.push_back(encode_instr(OP_BNZ, 0, 1, 0, 16'd0));   // r1 is zero
		prog_words.push_back(encode_instr(OP_ADDI, 8, 7, 0, 16'd1));
		prog_words.push_back(encode_instr(OP_HALT, 0, 0, 0, '0));
		close_program(2, 6);
	endtask

	task automatic expect_bit(string name, logic got, logic want);
		if (got !== want) begin
			tb_errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, want);
		end
	endtask

	//////////////////////////////////////////////////
	// Load and run
	task automatic load_program(int p, int from_word);
		for (int i = from_word; i < prog_len[p]; i++) begin
			@(negedge clock);
			load_valid = 1'b1;
			load_addr  = pc_t'(i);
			load_instr = prog_words[prog_first[p] + i];
			while (!load_ready) @(negedge clock);
		end
		@(negedge clock);
		load_valid = 1'b0;
	endtask

	task automatic run_program(int p);
		int wb_before;
		wb_before = wb_count;
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		expect_bit("busy", busy, 1'b1);
		if (p + 1 < NUM_PROGS) begin
			// Next program's first word, held off until the run ends
			load_valid = 1'b1;
			load_addr  = '0;
			load_instr = prog_words[prog_first[p + 1]];
			expect_bit("load_ready", load_ready, 1'b0);
			while (!load_ready) @(negedge clock);
			expect_bit("done", done, 1'b1);
			@(negedge clock);
			load_valid = 1'b0;
		end else begin
			while (!done) @(negedge clock);
		end
		expect_bit("busy", busy, 1'b0);
		if (wb_count - wb_before != prog_wb[p]) begin
			tb_errors++;
			$display("[FAIL] %0t wb_valid events: got %0d, expected %0d",
				$time, wb_count - wb_before, prog_wb[p]);
		end
	endtask

	initial begin
		clock      = 1'b0;
		reset      = 1'b1;
		load_valid = 1'b0;
		load_addr  = '0;
		load_instr = '0;
		start      = 1'b0;
		build_programs();
		cycle_limit = 64 * prog_words.size() + 200;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		expect_bit("busy", busy, 1'b0);
		expect_bit("done", done, 1'b0);
		expect_bit("wb_valid", wb_valid, 1'b0);
		expect_bit("load_ready", load_ready, 1'b1);

		load_program(0, 0);
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_program(p);
			if (p + 1 < NUM_PROGS) begin
				load_program(p + 1, 1);   // Word 0 landed at the end of the run
			end
		end
		repeat (3) @(negedge clock);

		$display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
design/scalar_pkg.sv
design/pipe_if.sv
design/instr_mem.sv
design/fetch_stage.sv
design/hazard_check.sv
design/reg_file.sv
design/exec_unit.sv
design/scalar_unit.sv
sim/scalar_checker.sv
sim/scalar_unit_asserts.sv
sim/tb_scalar_unit.sv

// ==== Makefile ====
# Verilator build for the scalar unit testbench

TOP = tb_scalar_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
